// File: src/gpu_defs.svh
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// Core geometry
`define WARPS_PER_CORE   2
`define THREADS_PER_WARP 4

// Word and address widths
`define DATA_WIDTH       16
`define INSTR_WIDTH      16
`define IMEM_ADDR_WIDTH  8
`define DMEM_ADDR_WIDTH  8

// Per-thread register file, one bank per warp
`define NUM_REGS         8
`define REG_ADDR_WIDTH   3

`endif

// File: src/gpu_pkg.sv
`default_nettype none

`include "gpu_defs.svh"

package gpu_pkg;

    typedef logic [`DATA_WIDTH-1:0]                    data_t;
    typedef logic [`INSTR_WIDTH-1:0]                   instruction_t;
    typedef logic [`IMEM_ADDR_WIDTH-1:0]               imem_addr_t;
    typedef logic [`DMEM_ADDR_WIDTH-1:0]               dmem_addr_t;
    typedef logic [$clog2(`WARPS_PER_CORE)-1:0]        warp_id_t;

    // Codes not listed here are turned into NOP by the decoder
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        MUL  = 4'd3,
        LDI  = 4'd4,
        TID  = 4'd5,
        STR  = 4'd6,
        HALT = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, REQUEST, WAIT, EXECUTE, UPDATE, DONE
    } warp_state_t;

    typedef enum logic [1:0] {F_IDLE, F_BUSY, F_DONE} fetch_state_t;

    typedef struct packed {
        opcode_t                    opcode;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [7:0]                 imm;
    } decoded_t;

endpackage

`default_nettype wire

// File: src/warp_issue_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

interface warp_issue_if import gpu_pkg::*; ();

    warp_id_t                       warp;
    decoded_t                       instr;
    logic                           request;
    logic                           execute;
    // One bit per lane, each lane drives its own
    wire [`THREADS_PER_WARP-1:0]    busy;

    modport scheduler (output warp, output instr, output request, output execute,
                       input busy);

    modport lane (input warp, input instr, input request, input execute,
                  output busy);

endinterface

`default_nettype wire

// File: src/instruction_fetcher.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module instruction_fetcher import gpu_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  logic         fetch_enable,
    input  imem_addr_t   pc,
    input  logic         read_ready,
    input  instruction_t read_data,
    output logic         read_valid,
    output imem_addr_t   read_address,
    output logic         fetch_done,
    output instruction_t instruction
);

    fetch_state_t state;

    // One read per fetch_enable episode
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= F_IDLE;
            read_valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (fetch_enable) begin
                        read_valid <= 1'b1;
                        state      <= F_BUSY;
                    end
                end
                F_BUSY: begin
                    if (read_ready) begin
                        read_valid <= 1'b0;
                        state      <= F_DONE;
                    end
                end
                F_DONE: begin
                    // Wait for the scheduler to release the request
                    if (!fetch_enable) begin
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Address held steady while valid is up, data taken with ready
    always_ff @(posedge clk) begin
        if (state == F_IDLE && fetch_enable) begin
            read_address <= pc;
        end
        if (state == F_BUSY && read_ready) begin
            instruction <= read_data;
        end
    end

    assign fetch_done = (state == F_DONE);

endmodule

`default_nettype wire

// File: src/instruction_decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module instruction_decoder import gpu_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  logic         capture,
    input  instruction_t instruction,
    output decoded_t     decoded
);

    opcode_t opcode;

    // Unknown codes collapse to NOP here so no one downstream checks again
    always_comb begin
        case (instruction[15:12])
            ADD, SUB, MUL, LDI, TID, STR, HALT: opcode = opcode_t'(instruction[15:12]);
            default:                            opcode = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (capture) begin
            decoded.opcode <= opcode;
            decoded.rd     <= instruction[11:9];
            decoded.rs1    <= instruction[8:6];
            decoded.rs2    <= instruction[5:3];
            // Immediate overlaps rs1 and rs2
            decoded.imm    <= instruction[7:0];
        end
    end

endmodule

`default_nettype wire

// File: src/warp_scheduler.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module warp_scheduler import gpu_pkg::*; (
    input  wire                         clk,
    input  wire                         reset,
    input  logic                        start,
    input  data_t                       num_warps,
    input  imem_addr_t                  base_address,
    input  logic [`WARPS_PER_CORE-1:0]  fetch_done,
    input  instruction_t                fetched_instr [`WARPS_PER_CORE],
    input  decoded_t                    decoded,
    output logic [`WARPS_PER_CORE-1:0]  fetch_enable,
    output imem_addr_t                  pc [`WARPS_PER_CORE],
    output instruction_t                current_instr,
    output logic                        capture,
    output logic                        done,
    warp_issue_if.scheduler             issue
);

    warp_state_t state [`WARPS_PER_CORE];
    warp_id_t    cur;
    warp_id_t    next_warp;
    logic        found;
    logic        switch_ok;
    logic        started;
    logic        all_done;

    always_comb begin
        for (int i = 0; i < `WARPS_PER_CORE; i++) begin
            fetch_enable[i] = (state[i] == FETCH);
        end
    end

    // Round robin over warps that are waiting in DECODE
    always_comb begin
        next_warp = cur;
        found     = 1'b0;
        for (int i = 1; i < `WARPS_PER_CORE; i++) begin
            if (!found && state[(int'(cur) + i) % `WARPS_PER_CORE] == DECODE) begin
                next_warp = warp_id_t'((int'(cur) + i) % `WARPS_PER_CORE);
                found     = 1'b1;
            end
        end
    end

    assign switch_ok = state[cur] inside {UPDATE, DONE, FETCH, IDLE};

    // Inactive warps never leave IDLE
    always_comb begin
        all_done = started;
        for (int i = 0; i < `WARPS_PER_CORE; i++) begin
            if (!(state[i] inside {DONE, IDLE})) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            done    <= 1'b0;
            cur     <= '0;
            for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                state[i] <= IDLE;
            end
        end else begin
            if (start && !started) begin
                started <= 1'b1;
                for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                    if (i < num_warps) begin
                        state[i] <= FETCH;
                    end
                end
            end
            // Fetch completes for any warp in parallel
            for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                if (state[i] == FETCH && fetch_done[i]) begin
                    state[i] <= DECODE;
                end
            end
            case (state[cur])
                DECODE:  state[cur] <= REQUEST;
                REQUEST: state[cur] <= WAIT;
                WAIT: begin
                    if (!(|issue.busy)) begin
                        state[cur] <= EXECUTE;
                    end
                end
                EXECUTE: state[cur] <= UPDATE;
                UPDATE:  state[cur] <= (decoded.opcode == HALT) ? DONE : FETCH;
                default: ;
            endcase
            if (switch_ok && found) begin
                cur <= next_warp;
            end
            done <= done | all_done;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `WARPS_PER_CORE; i++) begin
            if (start && !started && i < num_warps) begin
                pc[i] <= base_address;
            end else if (started && i == int'(cur) && state[i] == UPDATE
                         && decoded.opcode != HALT) begin
                pc[i] <= pc[i] + 1'b1;
            end
        end
    end

    assign current_instr = fetched_instr[cur];
    assign capture       = (state[cur] == DECODE);

    assign issue.warp    = cur;
    assign issue.instr   = decoded;
    assign issue.request = (state[cur] == REQUEST);
    assign issue.execute = (state[cur] == EXECUTE);

endmodule

`default_nettype wire

// File: src/thread_lane.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module thread_lane import gpu_pkg::*; #(
    parameter int LANE = 0
) (
    input  wire          clk,
    input  wire          reset,
    input  data_t        block_id,
    input  data_t        num_warps,
    input  logic         write_ready,
    output logic         write_valid,
    output dmem_addr_t   write_address,
    output data_t        write_data,
    warp_issue_if.lane   issue
);

    // One bank of registers per warp
    data_t regs [`WARPS_PER_CORE][`NUM_REGS];

    data_t rs1_val;
    data_t rs2_val;
    data_t tid;
    logic  launch;

    assign rs1_val = regs[issue.warp][issue.instr.rs1];
    assign rs2_val = regs[issue.warp][issue.instr.rs2];

    // Global thread id
    assign tid = data_t'(block_id * num_warps * `THREADS_PER_WARP
                         + issue.warp * `THREADS_PER_WARP + LANE);

    always_ff @(posedge clk) begin
        if (issue.execute) begin
            case (issue.instr.opcode)
                ADD: regs[issue.warp][issue.instr.rd] <= rs1_val + rs2_val;
                SUB: regs[issue.warp][issue.instr.rd] <= rs1_val - rs2_val;
                MUL: regs[issue.warp][issue.instr.rd] <= rs1_val * rs2_val;
                LDI: regs[issue.warp][issue.instr.rd] <= data_t'(issue.instr.imm);
                TID: regs[issue.warp][issue.instr.rd] <= tid;
                default: ;
            endcase
        end
    end

    assign launch = issue.request && issue.instr.opcode == STR;

    // Store handshake, held until the memory accepts
    always_ff @(posedge clk) begin
        if (reset) begin
            write_valid <= 1'b0;
        end else if (launch) begin
            write_valid <= 1'b1;
        end else if (write_ready) begin
            write_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            write_address <= rs1_val[`DMEM_ADDR_WIDTH-1:0];
            write_data    <= rs2_val;
        end
    end

    assign issue.busy[LANE] = write_valid;

endmodule

`default_nettype wire

// File: src/compute_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module compute_core import gpu_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  logic                          start,
    output logic                          done,
    input  data_t                         block_id,
    input  data_t                         num_warps,
    input  imem_addr_t                    base_address,
    // Instruction memory, one port per warp
    output logic [`WARPS_PER_CORE-1:0]    imem_read_valid,
    output imem_addr_t                    imem_read_address [`WARPS_PER_CORE],
    input  logic [`WARPS_PER_CORE-1:0]    imem_read_ready,
    input  instruction_t                  imem_read_data [`WARPS_PER_CORE],
    // Data memory, one write port per lane
    output logic [`THREADS_PER_WARP-1:0]  dmem_write_valid,
    output dmem_addr_t                    dmem_write_address [`THREADS_PER_WARP],
    output data_t                         dmem_write_data [`THREADS_PER_WARP],
    input  logic [`THREADS_PER_WARP-1:0]  dmem_write_ready
);

    logic [`WARPS_PER_CORE-1:0] fetch_enable;
    logic [`WARPS_PER_CORE-1:0] fetch_done;
    imem_addr_t                 pc [`WARPS_PER_CORE];
    instruction_t               fetched_instr [`WARPS_PER_CORE];
    instruction_t               current_instr;
    logic                       capture;
    decoded_t                   decoded;

    warp_issue_if issue ();

    warp_scheduler scheduler (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .num_warps     (num_warps),
        .base_address  (base_address),
        .fetch_done    (fetch_done),
        .fetched_instr (fetched_instr),
        .decoded       (decoded),
        .fetch_enable  (fetch_enable),
        .pc            (pc),
        .current_instr (current_instr),
        .capture       (capture),
        .done          (done),
        .issue         (issue.scheduler)
    );

    instruction_decoder decoder (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .instruction (current_instr),
        .decoded     (decoded)
    );

    for (genvar w = 0; w < `WARPS_PER_CORE; w++) begin : g_warp
        instruction_fetcher fetcher (
            .clk          (clk),
            .reset        (reset),
            .fetch_enable (fetch_enable[w]),
            .pc           (pc[w]),
            .read_ready   (imem_read_ready[w]),
            .read_data    (imem_read_data[w]),
            .read_valid   (imem_read_valid[w]),
            .read_address (imem_read_address[w]),
            .fetch_done   (fetch_done[w]),
            .instruction  (fetched_instr[w])
        );
    end

    for (genvar t = 0; t < `THREADS_PER_WARP; t++) begin : g_lane
        thread_lane #(
            .LANE (t)
        ) lane (
            .clk           (clk),
            .reset         (reset),
            .block_id      (block_id),
            .num_warps     (num_warps),
            .write_ready   (dmem_write_ready[t]),
            .write_valid   (dmem_write_valid[t]),
            .write_address (dmem_write_address[t]),
            .write_data    (dmem_write_data[t]),
            .issue         (issue.lane)
        );
    end

endmodule

`default_nettype wire

// File: verification/compute_core_asserts.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module compute_core_asserts import gpu_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  logic                          done,
    input  data_t                         num_warps,
    input  logic [`WARPS_PER_CORE-1:0]    imem_read_valid,
    input  imem_addr_t                    imem_read_address [`WARPS_PER_CORE],
    input  logic [`WARPS_PER_CORE-1:0]    imem_read_ready,
    input  logic [`THREADS_PER_WARP-1:0]  dmem_write_valid,
    input  dmem_addr_t                    dmem_write_address [`THREADS_PER_WARP],
    input  data_t                         dmem_write_data [`THREADS_PER_WARP],
    input  logic [`THREADS_PER_WARP-1:0]  dmem_write_ready
);

    int assert_errors = 0;

    // Quiet through reset and the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        reset |=> (imem_read_valid == '0 && dmem_write_valid == '0 && !done))
        else begin
            assert_errors = assert_errors + 1;
            $error("valid or done high during or right after reset");
        end

    done_held: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else begin
            assert_errors = assert_errors + 1;
            $error("done dropped before reset");
        end

    for (genvar w = 0; w < `WARPS_PER_CORE; w++) begin : g_imem
        imem_hold: assert property (@(posedge clk) disable iff (reset)
            imem_read_valid[w] && !imem_read_ready[w]
            |=> imem_read_valid[w] && $stable(imem_read_address[w]))
            else begin
                assert_errors = assert_errors + 1;
                $error("imem read request changed before ready");
            end
        imem_unused_warp: assert property (@(posedge clk) disable iff (reset)
            (w >= num_warps) |-> !imem_read_valid[w])
            else begin
                assert_errors = assert_errors + 1;
                $error("inactive warp fetched");
            end
        imem_after_done: assert property (@(posedge clk) disable iff (reset)
            done && !imem_read_valid[w] |=> !imem_read_valid[w])
            else begin
                assert_errors = assert_errors + 1;
                $error("imem valid rose after done");
            end
    end

    for (genvar t = 0; t < `THREADS_PER_WARP; t++) begin : g_dmem
        dmem_hold: assert property (@(posedge clk) disable iff (reset)
            dmem_write_valid[t] && !dmem_write_ready[t]
            |=> dmem_write_valid[t] && $stable(dmem_write_address[t])
                && $stable(dmem_write_data[t]))
            else begin
                assert_errors = assert_errors + 1;
                $error("dmem write request changed before ready");
            end
        dmem_after_done: assert property (@(posedge clk) disable iff (reset)
            done && !dmem_write_valid[t] |=> !dmem_write_valid[t])
            else begin
                assert_errors = assert_errors + 1;
                $error("dmem valid rose after done");
            end
    end

endmodule

`default_nettype wire

// File: verification/compute_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "gpu_defs.svh"

module compute_core_tb import gpu_pkg::*; ();

    localparam int W = `WARPS_PER_CORE;
    localparam int T = `THREADS_PER_WARP;
    // About ten times the length of one run of the ten-instruction kernel
    localparam int CYCLE_LIMIT = 3000;
    localparam int PROGRAM_LEN = 10;
    localparam int BASE        = 16;

    logic         clk;
    logic         reset;
    logic         start;
    logic         done;
    data_t        block_id;
    data_t        num_warps;
    imem_addr_t   base_address;
    logic [W-1:0] imem_read_valid;
    imem_addr_t   imem_read_address [W];
    logic [W-1:0] imem_read_ready;
    instruction_t imem_read_data [W];
    logic [T-1:0] dmem_write_valid;
    dmem_addr_t   dmem_write_address [T];
    data_t        dmem_write_data [T];
    logic [T-1:0] dmem_write_ready;

    instruction_t imem [256];
    data_t        dmem [256];
    int           write_count [256];
    int           fetch_count [W];
    int           writes_seen;
    int           errors;
    logic         timed_out;
    logic [31:0]  rng_state = 32'd57;

    compute_core uut (.*);

    bind compute_core compute_core_asserts checks (
        .clk                (clk),
        .reset              (reset),
        .done               (done),
        .num_warps          (num_warps),
        .imem_read_valid    (imem_read_valid),
        .imem_read_address  (imem_read_address),
        .imem_read_ready    (imem_read_ready),
        .dmem_write_valid   (dmem_write_valid),
        .dmem_write_address (dmem_write_address),
        .dmem_write_data    (dmem_write_data),
        .dmem_write_ready   (dmem_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instruction_t reg_word(input opcode_t op, input int rd, input int rs1,
                                              input int rs2);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
    endfunction

    function automatic instruction_t imm_word(input opcode_t op, input int rd, input int imm);
        return {op, rd[2:0], 1'b0, imm[7:0]};
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // Instruction memory answers the address on each port
    always_comb begin
        for (int w = 0; w < W; w++) begin
            imem_read_data[w] = imem[imem_read_address[w]];
        end
    end

    // Ready lines about half the time high
    always @(negedge clk) begin
        rng_state = xorshift(rng_state);
        imem_read_ready  = rng_state[9:8];
        dmem_write_ready = rng_state[3:0];
    end

    task automatic record_write(input int lane, input int addr, input int data);
        int first_tid;
        int tid;
        first_tid = int'(block_id) * int'(num_warps) * T;
        tid       = (addr >= 64) ? addr - 64 : addr;
        if (tid < first_tid || tid >= first_tid + int'(num_warps) * T) begin
            errors++;
            $display("Lane %0d wrote to unexpected address %0d at t=%0t", lane, addr, $time);
        end else begin
            check_value($sformatf("lane of thread %0d", tid), lane, tid % T);
        end
        dmem[addr] = data_t'(data);
        write_count[addr]++;
        writes_seen++;
    endtask

    // Sample handshakes at the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (!reset) begin
            for (int w = 0; w < W; w++) begin
                if (imem_read_valid[w] && imem_read_ready[w]) begin
                    check_value($sformatf("imem_read_address[%0d]", w),
                                int'(imem_read_address[w]), BASE + fetch_count[w]);
                    fetch_count[w]++;
                end
            end
            for (int t = 0; t < T; t++) begin
                if (dmem_write_valid[t] && dmem_write_ready[t]) begin
                    record_write(t, int'(dmem_write_address[t]), int'(dmem_write_data[t]));
                end
            end
        end
    end

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            // Opcode 7 decodes as NOP
            imem[a] = {8'h70, a[7:0]};
            dmem[a] = {8'hd0, a[7:0]};
        end
        imem[BASE + 0] = imm_word(TID, 1, 0);
        imem[BASE + 1] = imm_word(LDI, 2, 3);
        imem[BASE + 2] = reg_word(MUL, 3, 1, 2);
        imem[BASE + 3] = reg_word(ADD, 4, 3, 2);
        imem[BASE + 4] = reg_word(STR, 0, 1, 4);
        imem[BASE + 5] = reg_word(SUB, 5, 4, 1);
        imem[BASE + 6] = imm_word(LDI, 6, 64);
        imem[BASE + 7] = reg_word(ADD, 7, 6, 1);
        imem[BASE + 8] = reg_word(STR, 0, 7, 5);
        imem[BASE + 9] = imm_word(HALT, 0, 0);
    endtask

    task automatic run_block(input int warps, input int block);
        int cycles;
        int first_tid;
        @(negedge clk);
        reset     = 1'b1;
        start     = 1'b0;
        num_warps = data_t'(warps);
        block_id  = data_t'(block);
        writes_seen = 0;
        for (int a = 0; a < 256; a++) begin
            write_count[a] = 0;
        end
        for (int w = 0; w < W; w++) begin
            fetch_count[w] = 0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!done && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("Run with %0d warps: done never came within %0d cycles", warps, CYCLE_LIMIT);
        end else begin
            check_value("writes accepted before done", writes_seen, 2 * warps * T);
            first_tid = block * warps * T;
            for (int tid = first_tid; tid < first_tid + warps * T; tid++) begin
                check_value($sformatf("write count at %0d", tid), write_count[tid], 1);
                check_value($sformatf("write count at %0d", 64 + tid), write_count[64 + tid], 1);
                check_value($sformatf("dmem[%0d]", tid), int'(dmem[tid]), 3 * tid + 3);
                check_value($sformatf("dmem[%0d]", 64 + tid), int'(dmem[64 + tid]), 2 * tid + 3);
            end
            for (int w = 0; w < W; w++) begin
                check_value($sformatf("fetch count of warp %0d", w), fetch_count[w],
                            (w < warps) ? PROGRAM_LEN : 0);
            end
            repeat (20) @(negedge clk);
            check_value("done", int'(done), 1);
        end
    endtask

    initial begin
        errors           = 0;
        timed_out        = 1'b0;
        reset            = 1'b1;
        start            = 1'b0;
        block_id         = '0;
        num_warps        = data_t'(1);
        base_address     = imem_addr_t'(BASE);
        imem_read_ready  = '0;
        dmem_write_ready = '0;
        load_program();
        run_block(2, 1);
        if (!timed_out) begin
            run_block(1, 0);
        end
        $display("Checks done: %0d value errors, %0d assertion errors",
                 errors, uut.checks.assert_errors);
        if (errors == 0 && uut.checks.assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/gpu_pkg.sv
src/warp_issue_if.sv
src/instruction_fetcher.sv
src/instruction_decoder.sv
src/warp_scheduler.sv
src/thread_lane.sv
src/compute_core.sv
verification/compute_core_asserts.sv
verification/compute_core_tb.sv

// File: Makefile
TOP := compute_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
